// ==== files.f ====
common/edge_pkg.sv
hw/row_cache.sv
hw/window_buf.sv
hw/addr_gen.sv
hw/edge_ctrl.sv
hw/edge_top.sv
test/tb_edge_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the edge detector testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_edge_top -f files.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/tb_edge_top.sv ====
// testbench for the streaming 2x2 edge detector
// sdram model with variable read latency, reference gradient, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_edge_top
	import edge_pkg::*;
();

	localparam int N_IN    = IMG_W * IMG_H;
	localparam int N_OUT   = (IMG_W - 1) * (IMG_H - 1);
	localparam int TIMEOUT = 5000;                     // cycles per wait

	logic        clk, n_rst, start, sdram_rvalid, done;
	pix_t        sdram_rdata;
	sdram_req_t  sdram_req;

	pix_t        mem [0:(1 << SDRAM_AW) - 1];         // sdram contents
	sdram_addr_t rd_addr;
	sdram_addr_t wr_addr_q [$];
	pix_t        wr_data_q [$];
	int          lat_cnt, rd_count, done_count, err_count, test_err, tests_run;
	bit          rand_lat;
	string       cur_test;

	edge_top u_dut (
		.clk            (clk),
		.n_rst          (n_rst),
		.start_i        (start),
		.sdram_rvalid_i (sdram_rvalid),
		.sdram_rdata_i  (sdram_rdata),
		.sdram_req_o    (sdram_req),
		.done_o         (done)
	);

	always #50 clk = ~clk;                             // 100 ns period

	task automatic report_error(input string msg);
		$display("Error in %s: %s", cur_test, msg);
		err_count++;
		test_err++;
	endtask

	task automatic compare_pix(input string what, input pix_t exp, input pix_t act);
		if (exp !== act)
		begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			err_count++;
			test_err++;
		end
	endtask

	task automatic compare_addr(input string what, input sdram_addr_t exp, input sdram_addr_t act);
		if (exp !== act)
		begin
			$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
			test_err++;
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		if (exp != act)
		begin
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			err_count++;
			test_err++;
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
			err_count++;
			test_err++;
		end
	endtask

	// sdram model, answers each read after lat_cnt falling edges
	always @(negedge clk)
	begin
		sdram_rvalid = 1'b0;
		if (lat_cnt != 0)
		begin
			lat_cnt = lat_cnt - 1;
			if (lat_cnt == 0)
			begin
				sdram_rvalid = 1'b1;                   // single cycle answer
				sdram_rdata  = mem[rd_addr];           // held until next answer
			end
		end
		if (sdram_req.rd === 1'b1)
		begin
			rd_count++;
			rd_addr = sdram_req.addr;
			lat_cnt = rand_lat ? 1 + int'($urandom % 5) : 1;
			if (int'(sdram_req.addr) >= int'(IN_BASE) + N_IN)
				report_error("read address lies outside the input image");
		end
		if (sdram_req.wr === 1'b1)
		begin
			mem[sdram_req.addr] = sdram_req.wdata;
			wr_addr_q.push_back(sdram_req.addr);
			wr_data_q.push_back(sdram_req.wdata);
		end
		if (sdram_req.rd === 1'b1 && sdram_req.wr === 1'b1)
			report_error("read and write strobes high in the same cycle");
		if (done === 1'b1)
			done_count++;
	end

	function automatic int pixel_at(input int r, input int c);
		return int'(mem[int'(IN_BASE) + r * IMG_W + c]);
	endfunction

	// roberts cross on the window whose bottom-right pixel is (r, c)
	function automatic pix_t ref_grad(input int r, input int c);
		int d1, d2;
		d1 = pixel_at(r - 1, c - 1) - pixel_at(r, c);
		d2 = pixel_at(r - 1, c) - pixel_at(r, c - 1);
		d1 = (d1 < 0) ? -d1 : d1;
		d2 = (d2 < 0) ? -d2 : d2;
		return (d1 + d2 > 255) ? pix_t'(255) : pix_t'(d1 + d2);
	endfunction

	// kind 0 ramp, 1 random, 2 high contrast rows
	task automatic fill_image(input int kind);
		sdram_addr_t a;
		for (int r = 0; r < IMG_H; r++)
			for (int c = 0; c < IMG_W; c++)
			begin
				a = sdram_addr_t'(int'(IN_BASE) + r * IMG_W + c);
				case (kind)
					0:       mem[a] = pix_t'(r * 32 + c * 5);
					1:       mem[a] = pix_t'($urandom);
					default: mem[a] = (r % 2 == 1) ? ((c % 2 == 1) ? 8'd240 : 8'd255)
						: ((c % 2 == 1) ? 8'd15 : 8'd0);
				endcase
			end
	endtask

	task automatic check_run(input bit expect_sat, input int writes_at_done);
		int n;
		compare_count("writes before done", N_OUT, writes_at_done);
		compare_count("writes", N_OUT, wr_addr_q.size());
		compare_count("reads", N_IN, rd_count);
		compare_count("done pulses", 1, done_count);
		n = (wr_addr_q.size() < N_OUT) ? wr_addr_q.size() : N_OUT;
		for (int i = 0; i < n; i++)
		begin
			compare_addr("address", OUT_BASE + sdram_addr_t'(i), wr_addr_q[i]); // raster order
			compare_pix("pixel", ref_grad(i / (IMG_W - 1) + 1, i % (IMG_W - 1) + 1),
				wr_data_q[i]);
			if (expect_sat)
				compare_pix("saturation", 8'hff, wr_data_q[i]);
		end
	endtask

	// called at a rising edge
	task automatic run_image(input string name, input bit random_lat, input bit expect_sat);
		int waited;
		int writes_at_done;
		cur_test = name;
		test_err = 0;
		rand_lat = random_lat;
		wr_addr_q.delete();
		wr_data_q.delete();
		rd_count   = 0;
		done_count = 0;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		waited = 0;
		while (done !== 1'b1 && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1)
			report_error($sformatf("no done pulse after %0d cycles", TIMEOUT));
		else
		begin
			writes_at_done = wr_addr_q.size();     // no write in the done cycle
			repeat (3) @(posedge clk);             // catch late writes or a second done
			check_run(expect_sat, writes_at_done);
		end
		tests_run++;
		if (test_err == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_err);
	endtask

	task automatic test_reset();
		cur_test = "reset";
		test_err = 0;
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			if (i == 16)
				n_rst = 1'b1;                          // release after 16 cycles
			compare_bit("rd strobe", 1'b0, sdram_req.rd);
			compare_bit("wr strobe", 1'b0, sdram_req.wr);
			compare_bit("done", 1'b0, done);
		end
		@(posedge clk);
		tests_run++;
		if (test_err == 0)
			$display("reset: ok");
		else
			$display("reset: %0d errors", test_err);
	endtask

	task automatic test_ramp();
		fill_image(0);
		run_image("ramp latency 1", 1'b0, 1'b0);
	endtask

	task automatic test_random_latency();
		fill_image(1);
		run_image("random latency 1 to 5", 1'b1, 1'b0);
	endtask

	task automatic test_checkerboard();
		fill_image(2);
		run_image("contrast saturation", 1'b0, 1'b1);
	endtask

	task automatic test_restart();
		fill_image(1);
		run_image("second start", 1'b1, 1'b0);  // counters must have wrapped
	endtask

	initial
	begin
		clk          = 1'b0;
		n_rst        = 1'b0;
		start        = 1'b0;
		sdram_rvalid = 1'b0;
		sdram_rdata  = '0;
		lat_cnt      = 0;
		rand_lat     = 1'b0;
		err_count    = 0;
		tests_run    = 0;
		void'($urandom(32'h1d50_40fc));
		test_reset();
		test_ramp();
		test_random_latency();
		test_checkerboard();
		test_restart();
		$display("tests %0d, errors %0d", tests_run, err_count);
		if (err_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/edge_top.sv ====
// streaming 2x2 edge detector top
// ties controller, counters, row cache and window to the sdram port
`timescale 1ns/1ps
`default_nettype none

module edge_top import edge_pkg::*;
(
	input  wire         clk,
	input  wire         n_rst,
	input  wire         start_i,
	input  wire         sdram_rvalid_i,
	input  pix_t        sdram_rdata_i,
	output sdram_req_t  sdram_req_o,
	output logic        done_o
);

	ctrl_cmd_t   cmd;
	logic        sdram_rd, sdram_wr;
	logic        col_last, row_last;
	col_t        col;
	sdram_addr_t sdram_addr;
	pix_t        cache_pix;
	pix_t        grad;

	edge_ctrl u_ctrl (
		.clk            (clk),
		.n_rst          (n_rst),
		.start_i        (start_i),
		.sdram_rvalid_i (sdram_rvalid_i),
		.col_last_i     (col_last),
		.row_last_i     (row_last),
		.cmd_o          (cmd),
		.sdram_rd_o     (sdram_rd),
		.sdram_wr_o     (sdram_wr),
		.done_o         (done_o)
	);

	addr_gen u_addr (
		.clk          (clk),
		.n_rst        (n_rst),
		.col_step_i   (cmd.col_step),
		.row_step_i   (cmd.row_step),
		.addr_sel_i   (cmd.addr_sel),
		.col_o        (col),
		.col_last_o   (col_last),
		.row_last_o   (row_last),
		.sdram_addr_o (sdram_addr)
	);

	row_cache u_cache (
		.clk     (clk),
		.re_i    (cmd.cache_re),
		.we_i    (cmd.cache_we),
		.addr_i  (col),
		.wdata_i (sdram_rdata_i),      // new lower pixel becomes next upper row
		.rdata_o (cache_pix)
	);

	window_buf u_win (
		.clk         (clk),
		.n_rst       (n_rst),
		.en_i        (cmd.wb_en),
		.mode_i      (cmd.wb_mode),
		.sdram_pix_i (sdram_rdata_i),
		.cache_pix_i (cache_pix),
		.grad_o      (grad)
	);

	assign sdram_req_o = '{rd: sdram_rd, wr: sdram_wr, addr: sdram_addr, wdata: grad};

endmodule

`default_nettype wire

// ==== hw/edge_ctrl.sv ====
// edge detector scan controller
// walks the image: first row into the row cache, then per row a column-0
// fill and per column a window fill, gradient write, shift and step
`timescale 1ns/1ps
`default_nettype none

module edge_ctrl import edge_pkg::*;
(
	input  wire        clk,
	input  wire        n_rst,
	input  wire        start_i,
	input  wire        sdram_rvalid_i,
	input  wire        col_last_i,
	input  wire        row_last_i,
	output ctrl_cmd_t  cmd_o,
	output logic       sdram_rd_o,
	output logic       sdram_wr_o,
	output logic       done_o
);

	ctrl_state_e state, next_state;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:     if (start_i) next_state = S_FR_RD;
			S_FR_RD:    next_state = S_FR_WAIT;
			S_FR_WAIT:  if (sdram_rvalid_i) next_state = S_FR_STORE;
			S_FR_STORE: next_state = col_last_i ? S_ROW_STEP : S_FR_RD; // end of first row
			S_ROW_STEP: next_state = S_C0_RD;
			S_C0_RD:    next_state = S_C0_WAIT;
			S_C0_WAIT:  if (sdram_rvalid_i) next_state = S_C0_BL;
			S_C0_BL:    next_state = S_C0_TL;
			S_C0_TL:    next_state = S_CN_CRD;
			S_CN_CRD:   next_state = S_CN_TR;
			S_CN_TR:    next_state = S_CN_WAIT;
			S_CN_WAIT:  if (sdram_rvalid_i) next_state = S_CN_BR;
			S_CN_BR:    next_state = S_CN_WR;
			S_CN_WR:
			begin
				if (!col_last_i)
					next_state = S_CN_CRD;  // next column
				else if (row_last_i)
					next_state = S_FINISH;  // last window written
				else
					next_state = S_C0_RD;   // next row
			end
			S_FINISH:   next_state = S_IDLE;
			default:    next_state = S_IDLE;
		endcase
	end

	// per state output decode, everything idles low
	always_comb
	begin
		cmd_o      = '0;
		sdram_rd_o = 1'b0;
		sdram_wr_o = 1'b0;
		done_o     = 1'b0;
		case (state)
			S_FR_RD:    sdram_rd_o = 1'b1;             // first row pixel
			S_FR_STORE:
			begin
				cmd_o.cache_we = 1'b1;                 // pixel into row cache
				cmd_o.col_step = 1'b1;
			end
			S_ROW_STEP: cmd_o.row_step = 1'b1;         // row 0 done, col already wrapped
			S_C0_RD:    sdram_rd_o = 1'b1;             // lower pixel, column 0
			S_C0_BL:
			begin
				cmd_o.wb_en    = 1'b1;
				cmd_o.wb_mode  = LOAD_BL;
				cmd_o.cache_re = 1'b1;                 // upper pixel, column 0
			end
			S_C0_TL:
			begin
				cmd_o.wb_en    = 1'b1;
				cmd_o.wb_mode  = LOAD_TL;              // cache data valid now
				cmd_o.cache_we = 1'b1;                 // rdata still held by sdram
				cmd_o.col_step = 1'b1;
			end
			S_CN_CRD:   cmd_o.cache_re = 1'b1;         // upper pixel for TR
			S_CN_TR:
			begin
				cmd_o.wb_en   = 1'b1;
				cmd_o.wb_mode = LOAD_TR;
				sdram_rd_o    = 1'b1;                  // lower pixel for BR
			end
			S_CN_BR:
			begin
				cmd_o.wb_en    = 1'b1;
				cmd_o.wb_mode  = LOAD_BR;
				cmd_o.cache_we = 1'b1;                 // becomes upper row later
			end
			S_CN_WR:
			begin
				sdram_wr_o     = 1'b1;                 // gradient out
				cmd_o.addr_sel = WR_OUT;
				cmd_o.wb_en    = 1'b1;
				cmd_o.wb_mode  = SHIFT;                // takes effect after the write
				cmd_o.col_step = 1'b1;
				cmd_o.row_step = col_last_i;           // row ends here
			end
			S_FINISH:   done_o = 1'b1;
			default:    ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/addr_gen.sv ====
// column and row scan counters
// wrap flags for the controller and the sdram address for
// input reads and gradient writes
`timescale 1ns/1ps
`default_nettype none

module addr_gen import edge_pkg::*;
(
	input  wire          clk,
	input  wire          n_rst,
	input  wire          col_step_i,
	input  wire          row_step_i,
	input  addr_sel_e    addr_sel_i,
	output col_t         col_o,
	output logic         col_last_o,
	output logic         row_last_o,
	output sdram_addr_t  sdram_addr_o
);

	col_t        col_q;
	row_t        row_q;
	sdram_addr_t col_a;
	sdram_addr_t row_a;

	assign col_last_o = (col_q == col_t'(IMG_W - 1));
	assign row_last_o = (row_q == row_t'(IMG_H - 1));

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			col_q <= '0;
			row_q <= '0;
		end
		else
		begin
			if (col_step_i)
				col_q <= col_last_o ? '0 : col_q + 1'b1;  // rollover
			if (row_step_i)
				row_q <= row_last_o ? '0 : row_q + 1'b1;  // ready for next run
		end
	end

	assign col_a = sdram_addr_t'(col_q);
	assign row_a = sdram_addr_t'(row_q);

	always_comb
	begin
		if (addr_sel_i == WR_OUT)
			// output image is one smaller each way, window anchored at (col-1, row-1)
			sdram_addr_o = OUT_BASE
				+ (row_a - sdram_addr_t'(1)) * sdram_addr_t'(IMG_W - 1)
				+ (col_a - sdram_addr_t'(1));
		else
			sdram_addr_o = IN_BASE + row_a * sdram_addr_t'(IMG_W) + col_a;
	end

	assign col_o = col_q;                  // row cache address

endmodule

`default_nettype wire

// ==== hw/window_buf.sv ====
// 2x2 window buffer with roberts cross gradient
// top pixels load from the row cache, bottom ones from sdram
`timescale 1ns/1ps
`default_nettype none

module window_buf import edge_pkg::*;
(
	input  wire       clk,
	input  wire       n_rst,
	input  wire       en_i,
	input  wb_mode_e  mode_i,
	input  pix_t      sdram_pix_i,
	input  pix_t      cache_pix_i,
	output pix_t      grad_o
);

	pix_t             tl, tr, bl, br;
	pix_t             d_main, d_anti;
	logic [PIX_W:0]   sum;             // one carry bit

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			tl <= '0;
			tr <= '0;
			bl <= '0;
			br <= '0;
		end
		else if (en_i)                 // holds otherwise
		begin
			case (mode_i)
				LOAD_TL: tl <= cache_pix_i;
				LOAD_TR: tr <= cache_pix_i;
				LOAD_BL: bl <= sdram_pix_i;
				LOAD_BR: br <= sdram_pix_i;
				SHIFT:
				begin
					tl <= tr;          // slide one column right
					bl <= br;
				end
				default: ;
			endcase
		end
	end

	// absolute diagonal differences
	assign d_main = (tl > br) ? tl - br : br - tl;
	assign d_anti = (tr > bl) ? tr - bl : bl - tr;
	assign sum    = {1'b0, d_main} + {1'b0, d_anti};

	assign grad_o = sum[PIX_W] ? '1 : sum[PIX_W-1:0];  // clamp at full white

endmodule

`default_nettype wire

// ==== hw/row_cache.sv ====
// row cache holding one image row
// written as the scan passes, read back one cycle later for the upper row
`timescale 1ns/1ps
`default_nettype none

module row_cache import edge_pkg::*;
(
	input  wire   clk,
	input  wire   re_i,
	input  wire   we_i,
	input  col_t  addr_i,
	input  pix_t  wdata_i,
	output pix_t  rdata_o
);

	pix_t mem [IMG_W];

	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;    // done at this edge
		if (re_i)
			rdata_o <= mem[addr_i];    // valid next cycle, held until next re
	end

endmodule

`default_nettype wire

// ==== common/edge_pkg.sv ====
// edge detector shared definitions
// image geometry, memory map, datapath types and controller commands
`default_nettype none

package edge_pkg;

	localparam int IMG_W    = 8;                     // pixels per row
	localparam int IMG_H    = 6;                     // rows per image
	localparam int PIX_W    = 8;                     // grey-scale depth
	localparam int SDRAM_AW = 16;                    // word address bits
	localparam int COL_W    = $clog2(IMG_W);         // holds IMG_W-1
	localparam int ROW_W    = $clog2(IMG_H);         // holds IMG_H-1

	typedef logic [PIX_W-1:0]    pix_t;
	typedef logic [COL_W-1:0]    col_t;
	typedef logic [ROW_W-1:0]    row_t;
	typedef logic [SDRAM_AW-1:0] sdram_addr_t;

	localparam sdram_addr_t IN_BASE  = 16'h0000;     // input image
	localparam sdram_addr_t OUT_BASE = 16'h0100;     // gradient image

	// window ops, layout is | TL | TR | over | BL | BR |
	typedef enum logic [2:0] {
		LOAD_TL,                                     // top-left from cache
		LOAD_TR,                                     // top-right from cache
		LOAD_BL,                                     // bottom-left from sdram
		LOAD_BR,                                     // bottom-right from sdram
		SHIFT                                        // right column to left
	} wb_mode_e;

	typedef enum logic [4:0] {
		S_IDLE, S_FR_RD, S_FR_WAIT, S_FR_STORE, S_ROW_STEP,
		S_C0_RD, S_C0_WAIT, S_C0_BL, S_C0_TL,
		S_CN_CRD, S_CN_TR, S_CN_WAIT, S_CN_BR, S_CN_WR, S_FINISH
	} ctrl_state_e;

	typedef enum logic {
		RD_IN,                                       // input pixel (col, row)
		WR_OUT                                       // output pixel (col-1, row-1)
	} addr_sel_e;

	typedef struct packed {
		logic      col_step;                         // inc or wrap column
		logic      row_step;                         // inc or wrap row
		logic      cache_re;
		logic      cache_we;
		logic      wb_en;
		wb_mode_e  wb_mode;
		addr_sel_e addr_sel;
	} ctrl_cmd_t;

	typedef struct packed {
		logic        rd;                             // single cycle strobe
		logic        wr;                             // single cycle strobe
		sdram_addr_t addr;
		pix_t        wdata;
	} sdram_req_t;

endpackage

`default_nettype wire
